// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary -j 0 -f compile.f --top-module frame_decoder_tb \
		-Mdir obj_dir -o frame_decoder_sim
	./obj_dir/frame_decoder_sim | tee sim.log
	grep -qx "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/frame_decoder_checker.sv ====
`timescale 1ns/1ps

module frame_decoder_checker (
    input  logic                                  clk_in,
    input  logic                                  rst_in,
    input  logic [frame_decoder_pkg::BLOCK_W-1:0] payload_in,
    input  logic [frame_decoder_pkg::HDR_W-1:0]   header_in,
    input  logic                                  valid_in,
    input  logic [frame_decoder_pkg::BLOCK_W-1:0] m_axis_tdata,
    input  logic [frame_decoder_pkg::KEEP_W-1:0]  m_axis_tkeep,
    input  logic [frame_decoder_pkg::BYTE_W-1:0]  m_axis_tuser,
    input  logic [frame_decoder_pkg::BYTE_W-1:0]  m_axis_tdest,
    input  logic                                  m_axis_tlast,
    input  logic                                  m_axis_tvalid,
    input  logic                                  m_error,
    input  logic                                  pause_out,
    input  logic                                  unpause_out,
    input  logic [frame_decoder_pkg::BYTE_W-1:0]  pause_src_out,
    input  logic                                  flush,
    output int                                    mismatch_count,
    output int                                    event_errors,
    output int                                    open_events,
    output logic                                  flushed
);
    import frame_decoder_pkg::*;

    localparam int CARRY_W = BLOCK_W - SHIFT_BYTES * BYTE_W;

    typedef struct packed {
        logic [BLOCK_W-1:0] data;
        logic [KEEP_W-1:0]  keep;
        logic [BYTE_W-1:0]  user;
        logic [BYTE_W-1:0]  dest;
        logic               last;
    } beat_t;

    typedef struct packed {
        logic              is_pause;
        logic [BYTE_W-1:0] src;
    } flow_evt_t;

    beat_t             beat_q[$];
    flow_evt_t         flow_q[$];
    int                errors_due;

    // Reference decoder state
    logic              in_frame;
    logic              first_due;
    block_word_u       prev;
    logic [BYTE_W-1:0] tag_user;
    logic [BYTE_W-1:0] tag_dest;
    logic              any_event;

    function automatic block_kind_e classify(input logic [HDR_W-1:0] hdr,
                                             input logic [BYTE_W-1:0] t);
        if (hdr == HDR_DATA) begin
            return KIND_DATA;
        end
        if (hdr != HDR_CTRL) begin
            return KIND_UNKNOWN;
        end
        case (t)
            TYPE_S1, TYPE_S2, TYPE_S3, TYPE_S4: return KIND_START_SHORT;
            TYPE_S5:                            return KIND_START_LONG;
            TYPE_T0, TYPE_T1, TYPE_T2, TYPE_T3: return KIND_TERM;
            TYPE_IDLE:                          return KIND_IDLE;
            TYPE_PAUSE:                         return KIND_PAUSE;
            TYPE_ERROR:                         return KIND_ERROR;
            default:                            return KIND_UNKNOWN;
        endcase
    endfunction

    function automatic int byte_count(input logic [BYTE_W-1:0] t);
        case (t)
            TYPE_S1: return 1;
            TYPE_S2: return 2;
            TYPE_S3: return 3;
            TYPE_S4: return 4;
            TYPE_T1: return 1;
            TYPE_T2: return 2;
            TYPE_T3: return 3;
            default: return 0;
        endcase
    endfunction

    // Only the top nbytes of data survive, unused bytes read as zero
    task automatic push_beat(input logic [BLOCK_W-1:0] data, input int nbytes,
                             input logic last);
        beat_t b;
        b.data = data & ({BLOCK_W{1'b1}} << (BYTE_W * (KEEP_W - nbytes)));
        b.keep = {KEEP_W{1'b1}} << (KEEP_W - nbytes);
        b.user = tag_user;
        b.dest = tag_dest;
        b.last = last;
        beat_q.push_back(b);
    endtask

    task automatic model_block(input logic [BLOCK_W-1:0] payload,
                               input logic [HDR_W-1:0] hdr);
        block_word_u w;
        block_kind_e kind;
        int          n;
        flow_evt_t   f;
        w    = payload;
        kind = classify(hdr, w.frame.block_type);
        n    = byte_count(w.frame.block_type);

        // Frame is dropped and the block is seen again between frames
        if (in_frame && !(kind inside {KIND_DATA, KIND_TERM, KIND_PAUSE, KIND_IDLE})) begin
            in_frame = 1'b0;
        end

        if (kind == KIND_PAUSE) begin
            f.is_pause = &w.flow.quanta;
            f.src      = w.flow.source;
            flow_q.push_back(f);
        end else if (kind == KIND_IDLE) begin
            // Idle carries nothing
        end else if (in_frame && kind == KIND_DATA) begin
            if (first_due) begin
                tag_user  = prev.frame.user;
                tag_dest  = prev.frame.dest;
                first_due = 1'b0;
            end
            push_beat({prev.frame.lead, payload[BLOCK_W-1 -: CARRY_W]}, KEEP_W, 1'b0);
            prev = w;
        end else if (in_frame && kind == KIND_TERM) begin
            push_beat({prev.frame.lead, payload[BLOCK_W-BYTE_W-1 -: CARRY_W]},
                      SHIFT_BYTES + n, 1'b1);
            in_frame = 1'b0;
        end else if (kind == KIND_START_SHORT) begin
            tag_user = w.frame.user;
            tag_dest = w.frame.dest;
            push_beat({w.frame.lead, {CARRY_W{1'b0}}}, n, 1'b1);
        end else if (kind == KIND_START_LONG) begin
            in_frame  = 1'b1;
            first_due = 1'b1;
            prev      = w;
        end else begin
            errors_due++;
        end
    endtask

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_outputs();
        beat_t     b;
        flow_evt_t f;
        // Reset values until something is decoded
        if (!any_event && !(m_axis_tvalid || m_error || pause_out || unpause_out)) begin
            check_field("m_axis_tdata", 64'd0, m_axis_tdata);
            check_field("m_axis_tkeep", 64'd0, 64'(m_axis_tkeep));
            check_field("m_axis_tuser", 64'd0, 64'(m_axis_tuser));
            check_field("m_axis_tdest", 64'd0, 64'(m_axis_tdest));
            check_field("m_axis_tlast", 64'd0, 64'(m_axis_tlast));
            check_field("pause_src_out", 64'd0, 64'(pause_src_out));
        end

        if (m_axis_tvalid) begin
            any_event = 1'b1;
            if (beat_q.size() == 0) begin
                $display("Unexpected beat at %0t while no beat was expected", $time);
                event_errors++;
            end else begin
                b = beat_q.pop_front();
                check_field("m_axis_tdata", b.data, m_axis_tdata);
                check_field("m_axis_tkeep", 64'(b.keep), 64'(m_axis_tkeep));
                check_field("m_axis_tuser", 64'(b.user), 64'(m_axis_tuser));
                check_field("m_axis_tdest", 64'(b.dest), 64'(m_axis_tdest));
                check_field("m_axis_tlast", 64'(b.last), 64'(m_axis_tlast));
            end
        end

        if (m_error) begin
            any_event = 1'b1;
            if (errors_due == 0) begin
                $display("Unexpected error pulse at %0t", $time);
                event_errors++;
            end else begin
                errors_due--;
            end
        end

        if (pause_out && unpause_out) begin
            $display("Pause and unpause both high at %0t", $time);
            event_errors++;
        end else if (pause_out || unpause_out) begin
            any_event = 1'b1;
            if (flow_q.size() == 0) begin
                $display("Unexpected pause or unpause pulse at %0t", $time);
                event_errors++;
            end else begin
                f = flow_q.pop_front();
                check_field("pause_out", 64'(f.is_pause), 64'(pause_out));
                check_field("unpause_out", 64'(!f.is_pause), 64'(unpause_out));
                check_field("pause_src_out", 64'(f.src), 64'(pause_src_out));
            end
        end
    endtask

    task automatic report_leftovers();
        if (beat_q.size() != 0) begin
            $display("%0d expected beats never appeared", beat_q.size());
        end
        if (flow_q.size() != 0) begin
            $display("%0d expected pause or unpause pulses never appeared", flow_q.size());
        end
        if (errors_due != 0) begin
            $display("%0d expected error pulses never appeared", errors_due);
        end
        event_errors += beat_q.size() + flow_q.size() + errors_due;
        flushed = 1'b1;
    endtask

    always @(posedge clk_in) begin
        if (rst_in) begin
            beat_q.delete();
            flow_q.delete();
            errors_due     = 0;
            in_frame       = 1'b0;
            first_due      = 1'b0;
            prev           = '0;
            tag_user       = '0;
            tag_dest       = '0;
            any_event      = 1'b0;
            mismatch_count = 0;
            event_errors   = 0;
            flushed        = 1'b0;
        end else begin
            check_outputs();
            if (valid_in) begin
                model_block(payload_in, header_in);
            end
            if (flush && !flushed) begin
                report_leftovers();
            end
        end
        open_events = beat_q.size() + flow_q.size() + errors_due;
    end

endmodule

// ==== bench/frame_decoder_tb.sv ====
`timescale 1ns/1ps

module frame_decoder_tb;
    import frame_decoder_pkg::*;

    localparam int NUM_BLOCKS  = 2000;
    localparam int CYCLE_LIMIT = 2 * NUM_BLOCKS + 100;

    logic               clk_in;
    logic               rst_in;
    logic [BLOCK_W-1:0] payload_in;
    logic [HDR_W-1:0]   header_in;
    logic               valid_in;
    logic [BLOCK_W-1:0] m_axis_tdata;
    logic [KEEP_W-1:0]  m_axis_tkeep;
    logic [BYTE_W-1:0]  m_axis_tuser;
    logic [BYTE_W-1:0]  m_axis_tdest;
    logic               m_axis_tlast;
    logic               m_axis_tvalid;
    logic               m_error;
    logic               pause_out;
    logic               unpause_out;
    logic [BYTE_W-1:0]  pause_src_out;

    logic               flush;
    logic               flushed;
    int                 mismatch_count;
    int                 event_errors;
    int                 open_events;

    integer             seed;
    int                 slots;
    int                 cycle_count;
    logic               finishing;

    frame_decoder_top UUT (.*);

    frame_decoder_checker scoreboard (.*);

    initial begin
        clk_in = 1'b0;
        forever begin
            #50 clk_in = ~clk_in;
        end
    end

    function automatic int pick(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic [BLOCK_W-1:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [BLOCK_W-1:0] ctrl_word(input logic [BYTE_W-1:0] t);
        logic [BLOCK_W-1:0] w;
        w = rand_word();
        w[BLOCK_W-1 -: BYTE_W] = t;
        return w;
    endfunction

    function automatic bit is_known(input logic [BYTE_W-1:0] t);
        return t inside {TYPE_IDLE, TYPE_S1, TYPE_S2, TYPE_S3, TYPE_S4, TYPE_S5, TYPE_T0,
                         TYPE_T1, TYPE_T2, TYPE_T3, TYPE_ERROR, TYPE_PAUSE};
    endfunction

    task automatic send_block(input logic [HDR_W-1:0] hdr, input logic [BLOCK_W-1:0] word,
                              input logic valid);
        @(posedge clk_in);
        header_in  <= hdr;
        payload_in <= word;
        valid_in   <= valid;
        slots++;
    endtask

    task automatic send_ctrl(input logic [BYTE_W-1:0] t);
        send_block(HDR_CTRL, ctrl_word(t), 1'b1);
    endtask

    task automatic send_pause();
        block_word_u w;
        w = ctrl_word(TYPE_PAUSE);
        if (pick(2) == 0) begin
            w.flow.quanta = '1;
        end
        send_block(HDR_CTRL, w, 1'b1);
    endtask

    task automatic send_gap();
        send_block(2'(pick(4)), rand_word(), 1'b0);
    endtask

    // Idle, pause and gap slots inside or between frames
    task automatic send_fillers();
        int count;
        count = (pick(4) == 0) ? 1 + pick(2) : 0;
        for (int i = 0; i < count; i++) begin
            case (pick(3))
                0:       send_ctrl(TYPE_IDLE);
                1:       send_pause();
                default: send_gap();
            endcase
        end
    endtask

    task automatic send_fault();
        logic [BYTE_W-1:0] t;
        t = 8'(pick(256));
        case (pick(3))
            0: send_ctrl(TYPE_ERROR);
            1: send_block(pick(2) ? 2'b11 : 2'b00, rand_word(), 1'b1);
            default: begin
                if (is_known(t)) begin
                    t = 8'hd2;
                end
                send_ctrl(t);
            end
        endcase
        send_ctrl(TYPE_IDLE);
    endtask

    // Data or terminate block with no frame open
    task automatic send_stray();
        if (pick(2) == 0) begin
            send_block(HDR_DATA, rand_word(), 1'b1);
        end else begin
            send_ctrl(TYPE_T2);
        end
        send_ctrl(TYPE_IDLE);
    endtask

    task automatic send_short();
        case (pick(4))
            0:       send_ctrl(TYPE_S1);
            1:       send_ctrl(TYPE_S2);
            2:       send_ctrl(TYPE_S3);
            default: send_ctrl(TYPE_S4);
        endcase
    endtask

    task automatic send_long();
        int data_blocks;
        data_blocks = pick(7);
        send_ctrl(TYPE_S5);
        for (int i = 0; i < data_blocks; i++) begin
            send_fillers();
            send_block(HDR_DATA, rand_word(), 1'b1);
        end
        send_fillers();
        // Some frames are broken instead of terminated
        if (pick(8) == 0) begin
            send_fault();
        end else begin
            case (pick(4))
                0:       send_ctrl(TYPE_T0);
                1:       send_ctrl(TYPE_T1);
                2:       send_ctrl(TYPE_T2);
                default: send_ctrl(TYPE_T3);
            endcase
        end
    endtask

    task automatic finish_run(input logic timed_out);
        finishing = 1'b1;
        if (timed_out) begin
            $display("Timeout: run stopped after %0d cycles with %0d events still pending",
                     cycle_count, open_events);
        end
        @(posedge clk_in);
        flush <= 1'b1;
        while (!flushed) begin
            @(negedge clk_in);
        end
        $display("Errors: %0d mismatches, %0d event errors, %0d timeouts",
                 mismatch_count, event_errors, timed_out);
        if (!timed_out && mismatch_count == 0 && event_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        seed       = 32'ha4c4_17c2;
        rst_in     = 1'b1;
        payload_in = '0;
        header_in  = '0;
        valid_in   = 1'b0;
        flush      = 1'b0;
        finishing  = 1'b0;
        slots      = 0;
        repeat (2) @(posedge clk_in);
        rst_in <= 1'b0;

        while (slots < NUM_BLOCKS) begin
            send_fillers();
            case (pick(8))
                0, 1, 2:    send_short();
                3, 4, 5, 6: send_long();
                default: begin
                    if (pick(4) == 0) begin
                        send_stray();
                    end else begin
                        send_fault();
                    end
                end
            endcase
        end
        send_gap();
        send_gap();

        while (open_events != 0) begin
            @(negedge clk_in);
        end
        // Outputs trail the last block by at most two cycles
        repeat (4) @(posedge clk_in);
        if (!finishing) begin
            finish_run(1'b0);
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_in);
            cycle_count++;
        end
        if (!finishing) begin
            finish_run(1'b1);
        end
    end

endmodule

// ==== common/axis_beat_if.sv ====
`timescale 1ns/1ps

interface axis_beat_if;
    import frame_decoder_pkg::*;

    logic [BLOCK_W-1:0] tdata;
    logic [KEEP_W-1:0]  tkeep;
    logic [BYTE_W-1:0]  tuser;
    logic [BYTE_W-1:0]  tdest;
    logic               tlast;
    logic               tvalid;
    // Pulses once per rejected block
    logic               error;

    modport source (
        output tdata, tkeep, tuser, tdest, tlast, tvalid, error
    );

    modport sink (
        input tdata, tkeep, tuser, tdest, tlast, tvalid, error
    );

endinterface

// ==== common/frame_decoder_pkg.sv ====
package frame_decoder_pkg;

    // Line coding widths
    localparam int BLOCK_W = 64;
    localparam int HDR_W   = 2;
    localparam int BYTE_W  = 8;
    localparam int KEEP_W  = BLOCK_W / BYTE_W;

    // Bytes carried from one block into the next beat
    localparam int SHIFT_BYTES = 5;

    typedef enum logic [HDR_W-1:0] {
        HDR_DATA = 2'b01,
        HDR_CTRL = 2'b10
    } hdr_e;

    typedef enum logic [BYTE_W-1:0] {
        TYPE_IDLE  = 8'h00,
        TYPE_S1    = 8'h1e,
        TYPE_S2    = 8'h2d,
        TYPE_S3    = 8'h33,
        TYPE_S4    = 8'h4b,
        TYPE_S5    = 8'h55,
        TYPE_T0    = 8'h66,
        TYPE_T1    = 8'h78,
        TYPE_T2    = 8'h87,
        TYPE_T3    = 8'h99,
        TYPE_ERROR = 8'he1,
        TYPE_PAUSE = 8'hff
    } block_type_e;

    typedef enum logic [3:0] {
        KIND_INVALID,
        KIND_DATA,
        KIND_START_SHORT,
        KIND_START_LONG,
        KIND_TERM,
        KIND_IDLE,
        KIND_PAUSE,
        KIND_ERROR,
        KIND_UNKNOWN
    } block_kind_e;

    typedef enum logic [2:0] {
        BEAT_NONE,
        BEAT_SHORT,
        BEAT_FIRST,
        BEAT_MIDDLE,
        BEAT_TERM,
        BEAT_ERROR
    } beat_kind_e;

    typedef enum logic [1:0] {
        PSEL_NONE,
        PSEL_HELD,
        PSEL_INCOMING
    } pause_sel_e;

    typedef enum logic [1:0] {
        FRAME_IDLE,
        IN_FRAME,
        DRAIN
    } frame_state_e;

    // Start and terminate blocks
    typedef struct packed {
        logic [BYTE_W-1:0]             block_type;
        logic [BYTE_W-1:0]             user;
        logic [BYTE_W-1:0]             dest;
        logic [SHIFT_BYTES*BYTE_W-1:0] lead;
    } frame_view_t;

    // Pause and unpause blocks
    typedef struct packed {
        logic [BYTE_W-1:0] block_type;
        logic [BYTE_W-1:0] source;
        logic [BYTE_W-1:0] reserved;
        logic [31:0]       quanta;
        logic [BYTE_W-1:0] low;
    } flow_view_t;

    typedef union packed {
        frame_view_t frame;
        flow_view_t  flow;
    } block_word_u;

endpackage

// ==== compile.f ====
common/frame_decoder_pkg.sv
common/axis_beat_if.sv
src/block_classifier.sv
src/decoder_ctrl.sv
src/beat_assembler.sv
src/pause_decoder.sv
src/frame_decoder_top.sv
bench/frame_decoder_checker.sv
bench/frame_decoder_tb.sv

// ==== src/beat_assembler.sv ====
`timescale 1ns/1ps

module beat_assembler (
    input  logic                                  clk_in,
    input  logic                                  rst_in,
    input  logic [frame_decoder_pkg::BLOCK_W-1:0] held_payload,
    input  logic [frame_decoder_pkg::BLOCK_W-1:0] payload_in,
    input  frame_decoder_pkg::beat_kind_e         beat_kind,
    input  logic [2:0]                            beat_bytes,
    axis_beat_if.source                           beat
);
    import frame_decoder_pkg::*;

    localparam int LEAD_W  = SHIFT_BYTES * BYTE_W;
    localparam int CARRY_W = BLOCK_W - LEAD_W;

    block_word_u        held_w;
    logic [BLOCK_W-1:0] data_full;
    logic [BLOCK_W-1:0] byte_mask;
    logic [KEEP_W-1:0]  keep_next;
    logic               valid_next;
    logic               last_next;
    logic               error_next;
    logic               latch_tags;

    assign held_w = held_payload;

    always_comb begin
        data_full  = '0;
        keep_next  = '0;
        valid_next = 1'b0;
        last_next  = 1'b0;
        error_next = 1'b0;
        latch_tags = 1'b0;
        case (beat_kind)
            BEAT_SHORT: begin
                data_full  = {held_w.frame.lead, {CARRY_W{1'b0}}};
                keep_next  = ~({KEEP_W{1'b1}} >> beat_bytes);
                valid_next = 1'b1;
                last_next  = 1'b1;
                latch_tags = 1'b1;
            end
            BEAT_FIRST, BEAT_MIDDLE: begin
                data_full  = {held_w.frame.lead, payload_in[BLOCK_W-1 -: CARRY_W]};
                keep_next  = {KEEP_W{1'b1}};
                valid_next = 1'b1;
                latch_tags = (beat_kind == BEAT_FIRST);
            end
            BEAT_TERM: begin
                // Terminate bytes start right below the type byte
                data_full  = {held_w.frame.lead, payload_in[BLOCK_W-BYTE_W-1 -: CARRY_W]};
                keep_next  = ~({KEEP_W{1'b1}} >> (SHIFT_BYTES + int'(beat_bytes)));
                valid_next = 1'b1;
                last_next  = 1'b1;
            end
            BEAT_ERROR: begin
                error_next = 1'b1;
            end
            default: begin
            end
        endcase

        for (int i = 0; i < KEEP_W; i++) begin
            byte_mask[i*BYTE_W +: BYTE_W] = {BYTE_W{keep_next[i]}};
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            beat.tdata  <= '0;
            beat.tkeep  <= '0;
            beat.tuser  <= '0;
            beat.tdest  <= '0;
            beat.tlast  <= 1'b0;
            beat.tvalid <= 1'b0;
            beat.error  <= 1'b0;
        end else begin
            beat.tdata  <= data_full & byte_mask;
            beat.tkeep  <= keep_next;
            beat.tlast  <= last_next;
            beat.tvalid <= valid_next;
            beat.error  <= error_next;
            // Frame tags hold until the next start
            if (latch_tags) begin
                beat.tuser <= held_w.frame.user;
                beat.tdest <= held_w.frame.dest;
            end
        end
    end

endmodule

// ==== src/block_classifier.sv ====
`timescale 1ns/1ps

module block_classifier (
    input  logic [frame_decoder_pkg::HDR_W-1:0]  header,
    input  logic [frame_decoder_pkg::BYTE_W-1:0] type_byte,
    input  logic                                 valid,
    output frame_decoder_pkg::block_kind_e       kind,
    output logic [2:0]                           byte_count
);
    import frame_decoder_pkg::*;

    always_comb begin
        kind       = KIND_UNKNOWN;
        byte_count = 3'd0;
        if (!valid) begin
            kind = KIND_INVALID;
        end else if (header == HDR_DATA) begin
            kind = KIND_DATA;
        end else if (header == HDR_CTRL) begin
            case (type_byte)
                TYPE_S1:    begin kind = KIND_START_SHORT; byte_count = 3'd1; end
                TYPE_S2:    begin kind = KIND_START_SHORT; byte_count = 3'd2; end
                TYPE_S3:    begin kind = KIND_START_SHORT; byte_count = 3'd3; end
                TYPE_S4:    begin kind = KIND_START_SHORT; byte_count = 3'd4; end
                TYPE_S5:    kind = KIND_START_LONG;
                TYPE_T0:    begin kind = KIND_TERM; byte_count = 3'd0; end
                TYPE_T1:    begin kind = KIND_TERM; byte_count = 3'd1; end
                TYPE_T2:    begin kind = KIND_TERM; byte_count = 3'd2; end
                TYPE_T3:    begin kind = KIND_TERM; byte_count = 3'd3; end
                TYPE_IDLE:  kind = KIND_IDLE;
                TYPE_PAUSE: kind = KIND_PAUSE;
                TYPE_ERROR: kind = KIND_ERROR;
                // Spilling terminates land here as well
                default:    kind = KIND_UNKNOWN;
            endcase
        end
    end

endmodule

// ==== src/decoder_ctrl.sv ====
`timescale 1ns/1ps

module decoder_ctrl (
    input  logic                                  clk_in,
    input  logic                                  rst_in,
    input  logic [frame_decoder_pkg::BLOCK_W-1:0] payload_in,
    input  logic [frame_decoder_pkg::HDR_W-1:0]   header_in,
    input  logic                                  valid_in,
    input  frame_decoder_pkg::block_kind_e        in_kind,
    input  logic [2:0]                            in_bytes,
    input  frame_decoder_pkg::block_kind_e        held_kind,
    input  logic [2:0]                            held_bytes,
    output logic [frame_decoder_pkg::BLOCK_W-1:0] held_payload,
    output logic [frame_decoder_pkg::HDR_W-1:0]   held_header,
    output logic                                  held_valid,
    output frame_decoder_pkg::beat_kind_e         beat_kind,
    output logic [2:0]                            beat_bytes,
    output frame_decoder_pkg::pause_sel_e         pause_sel
);
    import frame_decoder_pkg::*;

    frame_state_e state;
    frame_state_e next_state;
    logic         load_held;
    logic         frame_open;

    // A held S5 waits on the incoming block just like an open frame
    assign frame_open = (state == IN_FRAME) || (held_kind == KIND_START_LONG);

    always_comb begin
        load_held  = 1'b1;
        beat_kind  = BEAT_NONE;
        beat_bytes = 3'd0;
        pause_sel  = PSEL_NONE;
        next_state = state;

        if (state == DRAIN) begin
            // Held terminate is dropped by loading over it
            next_state = FRAME_IDLE;
        end else begin
            case (held_kind)
                KIND_INVALID, KIND_IDLE: begin
                end
                KIND_PAUSE: begin
                    pause_sel = PSEL_HELD;
                end
                KIND_START_SHORT: begin
                    beat_kind  = BEAT_SHORT;
                    beat_bytes = held_bytes;
                end
                KIND_START_LONG, KIND_DATA: begin
                    if (frame_open) begin
                        case (in_kind)
                            KIND_DATA: begin
                                beat_kind  = (held_kind == KIND_START_LONG) ?
                                             BEAT_FIRST : BEAT_MIDDLE;
                                next_state = IN_FRAME;
                            end
                            KIND_TERM: begin
                                beat_kind  = BEAT_TERM;
                                beat_bytes = in_bytes;
                                next_state = DRAIN;
                            end
                            KIND_PAUSE: begin
                                pause_sel = PSEL_INCOMING;
                                load_held = 1'b0;
                            end
                            KIND_IDLE, KIND_INVALID: begin
                                load_held = 1'b0;
                            end
                            default: begin
                                // Frame dropped, offending block reported once held
                                next_state = FRAME_IDLE;
                            end
                        endcase
                    end else begin
                        beat_kind = BEAT_ERROR;
                    end
                end
                default: begin
                    beat_kind = BEAT_ERROR;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state      <= FRAME_IDLE;
            held_valid <= 1'b0;
        end else begin
            state <= next_state;
            if (load_held) begin
                held_valid <= valid_in;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (load_held) begin
            held_payload <= payload_in;
            held_header  <= header_in;
        end
    end

endmodule

// ==== src/frame_decoder_top.sv ====
`timescale 1ns/1ps

module frame_decoder_top (
    input  logic                                  clk_in,
    input  logic                                  rst_in,
    input  logic [frame_decoder_pkg::BLOCK_W-1:0] payload_in,
    input  logic [frame_decoder_pkg::HDR_W-1:0]   header_in,
    input  logic                                  valid_in,
    output logic [frame_decoder_pkg::BLOCK_W-1:0] m_axis_tdata,
    output logic [frame_decoder_pkg::KEEP_W-1:0]  m_axis_tkeep,
    output logic [frame_decoder_pkg::BYTE_W-1:0]  m_axis_tuser,
    output logic [frame_decoder_pkg::BYTE_W-1:0]  m_axis_tdest,
    output logic                                  m_axis_tlast,
    output logic                                  m_axis_tvalid,
    output logic                                  m_error,
    output logic                                  pause_out,
    output logic                                  unpause_out,
    output logic [frame_decoder_pkg::BYTE_W-1:0]  pause_src_out
);
    import frame_decoder_pkg::*;

    logic [BLOCK_W-1:0] held_payload;
    logic [HDR_W-1:0]   held_header;
    logic               held_valid;
    block_kind_e        held_kind;
    logic [2:0]         held_bytes;
    block_kind_e        in_kind;
    logic [2:0]         in_bytes;
    beat_kind_e         beat_kind;
    logic [2:0]         beat_bytes;
    pause_sel_e         pause_sel;

    axis_beat_if beat_bus ();

    decoder_ctrl ctrl (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .payload_in   (payload_in),
        .header_in    (header_in),
        .valid_in     (valid_in),
        .in_kind      (in_kind),
        .in_bytes     (in_bytes),
        .held_kind    (held_kind),
        .held_bytes   (held_bytes),
        .held_payload (held_payload),
        .held_header  (held_header),
        .held_valid   (held_valid),
        .beat_kind    (beat_kind),
        .beat_bytes   (beat_bytes),
        .pause_sel    (pause_sel)
    );

    block_classifier held_cls (
        .header     (held_header),
        .type_byte  (held_payload[BLOCK_W-1 -: BYTE_W]),
        .valid      (held_valid),
        .kind       (held_kind),
        .byte_count (held_bytes)
    );

    block_classifier in_cls (
        .header     (header_in),
        .type_byte  (payload_in[BLOCK_W-1 -: BYTE_W]),
        .valid      (valid_in),
        .kind       (in_kind),
        .byte_count (in_bytes)
    );

    beat_assembler assembler (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .held_payload (held_payload),
        .payload_in   (payload_in),
        .beat_kind    (beat_kind),
        .beat_bytes   (beat_bytes),
        .beat         (beat_bus.source)
    );

    pause_decoder pause_dec (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .held_payload  (held_payload),
        .payload_in    (payload_in),
        .pause_sel     (pause_sel),
        .pause_out     (pause_out),
        .unpause_out   (unpause_out),
        .pause_src_out (pause_src_out)
    );

    assign m_axis_tdata  = beat_bus.tdata;
    assign m_axis_tkeep  = beat_bus.tkeep;
    assign m_axis_tuser  = beat_bus.tuser;
    assign m_axis_tdest  = beat_bus.tdest;
    assign m_axis_tlast  = beat_bus.tlast;
    assign m_axis_tvalid = beat_bus.tvalid;
    assign m_error       = beat_bus.error;

endmodule

// ==== src/pause_decoder.sv ====
`timescale 1ns/1ps

module pause_decoder (
    input  logic                                  clk_in,
    input  logic                                  rst_in,
    input  logic [frame_decoder_pkg::BLOCK_W-1:0] held_payload,
    input  logic [frame_decoder_pkg::BLOCK_W-1:0] payload_in,
    input  frame_decoder_pkg::pause_sel_e         pause_sel,
    output logic                                  pause_out,
    output logic                                  unpause_out,
    output logic [frame_decoder_pkg::BYTE_W-1:0]  pause_src_out
);
    import frame_decoder_pkg::*;

    block_word_u sel_w;
    logic        full_quanta;

    assign sel_w       = (pause_sel == PSEL_HELD) ? held_payload : payload_in;
    // All ones quanta means pause, anything else releases
    assign full_quanta = &sel_w.flow.quanta;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pause_out     <= 1'b0;
            unpause_out   <= 1'b0;
            pause_src_out <= '0;
        end else if (pause_sel != PSEL_NONE) begin
            pause_out     <= full_quanta;
            unpause_out   <= !full_quanta;
            pause_src_out <= sel_w.flow.source;
        end else begin
            pause_out     <= 1'b0;
            unpause_out   <= 1'b0;
            pause_src_out <= '0;
        end
    end

endmodule
